// File: kronos_exec.f
+incdir+source
source/kronos_types.sv
source/kronos_regfile.sv
source/kronos_decode.sv
source/kronos_ex.sv
source/kronos_wb.sv
source/kronos_core_ex.sv
verif/kronos_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the execute core testbench with Verilator and runs it
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module kronos_tb \
    -f kronos_exec.f \
    -Mdir obj_dir \
    -o kronos_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/kronos_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit "$sim_status"
fi

exit 0

// File: source/kronos_core_ex.sv
/* Execute core top level
   Decode, execute, writeback and register file */

`include "kronos_defs.svh"

module kronos_core_ex (
    input  logic                    clk,
    input  logic                    rstz,
    input  kronos_types::instr_t    instr,
    input  logic                    instr_vld,
    output logic                    instr_rdy,
    output kronos_types::pipeEXWB_t retire,
    output logic                    retire_vld,
    input  logic                    retire_rdy
);

kronos_types::pipeIDEX_t decode;
kronos_types::pipeEXWB_t execute;
logic id_vld, id_rdy, ex_vld, ex_rdy;
logic [`KRONOS_REG_AW-1:0] rs1_addr, rs2_addr, wr_addr;
logic [`KRONOS_XLEN-1:0] rs1_data, rs2_data, wr_data, fwd_data;
logic wr_en, fwd_vld;

// ========================================
// Pipeline stages

kronos_decode u_decode (
    .clk       (clk),
    .rstz      (rstz),
    .instr     (instr),
    .instr_vld (instr_vld),
    .instr_rdy (instr_rdy),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .decode    (decode),
    .id_vld    (id_vld),
    .id_rdy    (id_rdy)
);

kronos_ex u_ex (
    .clk      (clk),
    .rstz     (rstz),
    .decode   (decode),
    .id_vld   (id_vld),
    .id_rdy   (id_rdy),
    .execute  (execute),
    .ex_vld   (ex_vld),
    .ex_rdy   (ex_rdy),
    .fwd_data (fwd_data),
    .fwd_vld  (fwd_vld)
);

kronos_wb u_wb (
    .clk        (clk),
    .rstz       (rstz),
    .execute    (execute),
    .ex_vld     (ex_vld),
    .ex_rdy     (ex_rdy),
    .retire     (retire),
    .retire_vld (retire_vld),
    .retire_rdy (retire_rdy),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .fwd_data   (fwd_data),
    .fwd_vld    (fwd_vld)
);

// Decode reads, writeback writes
kronos_regfile u_regfile (
    .clk      (clk),
    .rstz     (rstz),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
);

endmodule

// File: source/kronos_decode.sv
/* Instruction buffer and decoder
   Field decode, immediate build and register read into the ID/EX pipe */

`include "kronos_defs.svh"

module kronos_decode (
    input  logic                      clk,
    input  logic                      rstz,
    input  kronos_types::instr_t      instr,
    input  logic                      instr_vld,
    output logic                      instr_rdy,
    output logic [`KRONOS_REG_AW-1:0] rs1_addr,
    output logic [`KRONOS_REG_AW-1:0] rs2_addr,
    input  logic [`KRONOS_XLEN-1:0]   rs1_data,
    input  logic [`KRONOS_XLEN-1:0]   rs2_data,
    output kronos_types::pipeIDEX_t   decode,
    output logic                      id_vld,
    input  logic                      id_rdy
);

kronos_types::instr_t instr_q;
logic buf_vld;
logic is_op, is_imm, legal;
logic [6:0] funct7;
logic [`KRONOS_XLEN-1:0] imm;

// ========================================
// Instruction buffer

// Refill when empty or when the held word moves on
assign instr_rdy = ~buf_vld | id_rdy;
assign id_vld    = buf_vld;

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) buf_vld <= 1'b0;
    else if (instr_rdy) buf_vld <= instr_vld;
end

always_ff @(posedge clk) begin
    if (instr_vld && instr_rdy) instr_q <= instr;
end

// ========================================
// Field decode

assign is_op  = instr_q.r_fmt.opcode == kronos_types::OPC_OP;
assign is_imm = instr_q.r_fmt.opcode == kronos_types::OPC_OP_IMM;

// Upper bits are funct7 for OP, top of the immediate for OP-IMM
assign funct7 = is_imm ? instr_q.i_fmt.imm12[11:5] : instr_q.r_fmt.funct7;

// Sign-extended I-type immediate
assign imm = {{(`KRONOS_XLEN-12){instr_q.i_fmt.imm12[11]}}, instr_q.i_fmt.imm12};

// Register file read, combinational
assign rs1_addr = instr_q.r_fmt.rs1;
assign rs2_addr = instr_q.r_fmt.rs2;

always_comb begin
    decode          = '0;
    decode.op1      = rs1_data;
    decode.op2      = is_imm ? imm : rs2_data;
    decode.rs1      = instr_q.r_fmt.rs1;
    decode.rs2      = instr_q.r_fmt.rs2;
    decode.rs1_read = is_op | is_imm;
    // OP-IMM takes op2 from the immediate
    decode.rs2_read = is_op;
    decode.rd       = instr_q.r_fmt.rd;
    decode.rd_write = 1'b1;
    decode.sel      = kronos_types::ALU_ADDER;
    legal           = is_op | is_imm;

    case (instr_q.r_fmt.funct3)
        3'b000: begin
            // ADD, ADDI, SUB
            if (is_op && funct7 == 7'b0100000) begin
                decode.neg = 1'b1;
                decode.cin = 1'b1;
            end
            else if (is_op && funct7 != 7'b0) legal = 1'b0;
        end
        3'b001: begin
            // Left shift runs reversed through the right shifter
            decode.sel = kronos_types::ALU_SHIFT;
            decode.rev = 1'b1;
            if (funct7 != 7'b0) legal = 1'b0;
        end
        3'b010, 3'b011: begin
            // SLT and SLTU subtract and look at sign or carry
            decode.sel = kronos_types::ALU_COMP;
            decode.neg = 1'b1;
            decode.cin = 1'b1;
            decode.uns = instr_q.r_fmt.funct3[0];
            decode.eq  = 1'b0;
            decode.inv = 1'b0;
            if (is_op && funct7 != 7'b0) legal = 1'b0;
        end
        3'b101: begin
            // SRL or SRA, cin selects sign fill
            decode.sel = kronos_types::ALU_SHIFT;
            decode.shr = 1'b1;
            if (funct7 == 7'b0100000) decode.cin = 1'b1;
            else if (funct7 != 7'b0) legal = 1'b0;
        end
        default: begin
            // XOR, OR and AND share the logic unit
            case (instr_q.r_fmt.funct3)
                3'b100:  decode.sel = kronos_types::ALU_XOR;
                3'b110:  decode.sel = kronos_types::ALU_OR;
                default: decode.sel = kronos_types::ALU_AND;
            endcase
            if (is_op && funct7 != 7'b0) legal = 1'b0;
        end
    endcase

    // Unknown encodings retire with no write
    if (!legal) begin
        decode.illegal  = 1'b1;
        decode.rd_write = 1'b0;
    end
end

endmodule

// File: source/kronos_defs.svh
/* Global sizing macros for the execute core
   Data width, register count and register index width */

`ifndef KRONOS_DEFS_SVH
`define KRONOS_DEFS_SVH

// ========================================
// Datapath

// Integer register and ALU width
`define KRONOS_XLEN 32

// ========================================
// Register file

// Architectural integer registers, x0 included
`define KRONOS_NREGS 32

// Bits needed to index one register
`define KRONOS_REG_AW 5

`endif

// File: source/kronos_ex.sv
/* Two-cycle ALU with hazard forwarding
   Carry-select adder, logic unit, comparator, barrel shifter and sequencer */

`include "kronos_defs.svh"

module kronos_ex (
    input  logic                    clk,
    input  logic                    rstz,
    input  kronos_types::pipeIDEX_t decode,
    input  logic                    id_vld,
    output logic                    id_rdy,
    output kronos_types::pipeEXWB_t execute,
    output logic                    ex_vld,
    input  logic                    ex_rdy,
    input  logic [`KRONOS_XLEN-1:0] fwd_data,
    input  logic                    fwd_vld
);

localparam int HALF = `KRONOS_XLEN / 2;

typedef enum logic {EX1, EX2} ex_state_t;
ex_state_t state, next_state;

logic accept;
logic is_pending, pend_wb, use_fwd;
logic [`KRONOS_REG_AW-1:0] rpend;
logic rs1_hazard, rs2_hazard;
logic [`KRONOS_XLEN-1:0] op1, op2, adder_b, logic_res;
logic [HALF-1:0] adder_rl, adder_rh0, adder_rh1;
logic cout_rl, cout_rh0, cout_rh1, cout;
logic [`KRONOS_XLEN-1:0] r_adder, r_logic;
logic a_sign, b_sign, eq_l, eq_h;
logic check_uns, check_eq, invert;
logic lt, ltu, eq, r_comp;
logic [`KRONOS_XLEN-1:0] shift_in, shift_q, r_shift;
logic [2*`KRONOS_XLEN-1:0] shift_coarse, shift_fine;
logic shift_fill, fill_q, rev_q;
logic [2:0] shamt_lo;
kronos_types::alu_sel_t sel_q;

// ========================================
// Hazard check

// Only the last accepted writer is tracked, older ones are written by now
assign rs1_hazard = is_pending && decode.rs1_read && (decode.rs1 == rpend);
assign rs2_hazard = is_pending && decode.rs2_read && (decode.rs2 == rpend);

// Tracked result sitting in writeback
assign use_fwd = pend_wb && fwd_vld;
assign op1 = (rs1_hazard && use_fwd) ? fwd_data : decode.op1;
assign op2 = (rs2_hazard && use_fwd) ? fwd_data : decode.op2;

// Hold off while the result is still inside execute
assign id_rdy = (state == EX1) && (~ex_vld || ex_rdy)
             && !((rs1_hazard || rs2_hazard) && !pend_wb);
assign accept = id_vld && id_rdy;

// ========================================
// EX1 datapath

// Negated op2 plus cin gives op1 - op2
assign adder_b = decode.neg ? ~op2 : op2;

// Logic unit, only one result is kept
always_comb begin
    case (decode.sel)
        kronos_types::ALU_AND: logic_res = op1 & op2;
        kronos_types::ALU_OR:  logic_res = op1 | op2;
        default:               logic_res = op1 ^ op2;
    endcase
end

// Shifter stage 1 moves by whole bytes
assign shift_in     = decode.rev ? {<<{op1}} : op1;
assign shift_fill   = decode.shr & decode.cin & op1[`KRONOS_XLEN-1];
assign shift_coarse = {{`KRONOS_XLEN{shift_fill}}, shift_in} >> {op2[4:3], 3'b000};

always_ff @(posedge clk) begin
    // Low half and both guesses for the high half
    {cout_rl, adder_rl} <= {1'b0, op1[HALF-1:0]} + {1'b0, adder_b[HALF-1:0]}
                         + {{HALF{1'b0}}, decode.cin};
    {cout_rh0, adder_rh0} <= {1'b0, op1[`KRONOS_XLEN-1:HALF]}
                           + {1'b0, adder_b[`KRONOS_XLEN-1:HALF]};
    {cout_rh1, adder_rh1} <= {1'b0, op1[`KRONOS_XLEN-1:HALF]}
                           + {1'b0, adder_b[`KRONOS_XLEN-1:HALF]} + {{HALF{1'b0}}, 1'b1};
    r_logic <= logic_res;

    // Comparator inputs for the second cycle
    a_sign    <= op1[`KRONOS_XLEN-1];
    b_sign    <= op2[`KRONOS_XLEN-1];
    check_uns <= decode.uns;
    check_eq  <= decode.eq;
    invert    <= decode.inv;
    eq_l      <= op1[HALF-1:0] == op2[HALF-1:0];
    eq_h      <= op1[`KRONOS_XLEN-1:HALF] == op2[`KRONOS_XLEN-1:HALF];

    shift_q  <= shift_coarse[`KRONOS_XLEN-1:0];
    fill_q   <= shift_fill;
    rev_q    <= decode.rev;
    shamt_lo <= op2[2:0];
    sel_q    <= decode.sel;
end

// ========================================
// EX2 datapath

// Low carry picks the high half
assign r_adder = {cout_rl ? adder_rh1 : adder_rh0, adder_rl};
assign cout    = cout_rl ? cout_rh1 : cout_rh0;

always_comb begin
    // Same signs cannot overflow, so the difference sign decides
    case ({a_sign, b_sign})
        2'b01:   lt = 1'b0;
        2'b10:   lt = 1'b1;
        default: lt = r_adder[`KRONOS_XLEN-1];
    endcase
    // No borrow out means op1 >= op2 unsigned
    ltu = ~cout;
    eq  = eq_l & eq_h;
    if (check_eq) r_comp = invert ? ~eq : eq;
    else if (check_uns) r_comp = invert ? ~ltu : ltu;
    else r_comp = invert ? ~lt : lt;
end

// Shifter stage 2, bit steps then undo the reversal
assign shift_fine = {{`KRONOS_XLEN{fill_q}}, shift_q} >> shamt_lo;
assign r_shift    = rev_q ? {<<{shift_fine[`KRONOS_XLEN-1:0]}} : shift_fine[`KRONOS_XLEN-1:0];

// ========================================
// Sequencer

always_comb begin
    next_state = EX1;
    if (state == EX1 && accept) next_state = EX2;
end

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        state      <= EX1;
        ex_vld     <= 1'b0;
        is_pending <= 1'b0;
        pend_wb    <= 1'b0;
        rpend      <= '0;
    end
    else begin
        state <= next_state;
        if (state == EX2) ex_vld <= 1'b1;
        else if (ex_rdy) ex_vld <= 1'b0;

        if (accept) begin
            // x0 never needs forwarding
            is_pending <= decode.rd_write && (decode.rd != '0);
            pend_wb    <= 1'b0;
            rpend      <= decode.rd;
        end
        else if (ex_vld && ex_rdy) pend_wb <= is_pending;
        else if (pend_wb && !fwd_vld) begin
            // Written back, the register file is current again
            is_pending <= 1'b0;
            pend_wb    <= 1'b0;
        end
    end
end

// Controls on accept, result at the end of EX2
always_ff @(posedge clk) begin
    if (accept) begin
        execute.rd       <= decode.rd;
        execute.rd_write <= decode.rd_write;
        execute.illegal  <= decode.illegal;
    end
    if (state == EX2) begin
        case (sel_q)
            kronos_types::ALU_ADDER: execute.result1 <= r_adder;
            kronos_types::ALU_COMP:  execute.result1 <= {{(`KRONOS_XLEN-1){1'b0}}, r_comp};
            kronos_types::ALU_SHIFT: execute.result1 <= r_shift;
            default:                 execute.result1 <= r_logic;
        endcase
    end
end

// ========================================
// Assertions

a_vld_from_ex2: assert property (@(posedge clk) disable iff (!rstz)
    $rose(ex_vld) |-> $past(state) == EX2);

a_no_accept_ex2: assert property (@(posedge clk) disable iff (!rstz)
    (state == EX2) |-> !(id_vld && id_rdy));

a_out_stable: assert property (@(posedge clk) disable iff (!rstz)
    (ex_vld && !ex_rdy) |=> ex_vld && $stable(execute));

endmodule

// File: source/kronos_regfile.sv
/* Integer register file, 2 read ports and 1 write port
   x0 reads as zero, a same-cycle write passes straight to the read ports */

`include "kronos_defs.svh"

module kronos_regfile (
    input  logic                      clk,
    input  logic                      rstz,
    input  logic [`KRONOS_REG_AW-1:0] rs1_addr,
    input  logic [`KRONOS_REG_AW-1:0] rs2_addr,
    output logic [`KRONOS_XLEN-1:0]   rs1_data,
    output logic [`KRONOS_XLEN-1:0]   rs2_data,
    input  logic                      wr_en,
    input  logic [`KRONOS_REG_AW-1:0] wr_addr,
    input  logic [`KRONOS_XLEN-1:0]   wr_data
);

logic [`KRONOS_XLEN-1:0] regs [`KRONOS_NREGS];

// One read port
function automatic logic [`KRONOS_XLEN-1:0] read_port(
    input logic [`KRONOS_REG_AW-1:0] addr
);
    logic [`KRONOS_XLEN-1:0] data;
    if (addr == '0) data = '0;
    // Bypass a write landing this edge
    else if (wr_en && wr_addr == addr) data = wr_data;
    else data = regs[addr];
    return data;
endfunction

always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
end

// Writes to x0 are dropped
always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        for (int i = 0; i < `KRONOS_NREGS; i++) regs[i] <= '0;
    end
    else if (wr_en && wr_addr != '0) begin
        regs[wr_addr] <= wr_data;
    end
end

a_wr_addr_known: assert property (@(posedge clk) disable iff (!rstz)
    wr_en |-> !$isunknown(wr_addr));

endmodule

// File: source/kronos_types.sv
/* Shared types for the execute core
   Opcodes, ALU select, instruction union and pipe structs */

`include "kronos_defs.svh"

package kronos_types;

// Major opcodes that this core executes
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

// Result source picked in EX2
typedef enum logic [2:0] {
    ALU_ADDER,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_COMP,
    ALU_SHIFT
} alu_sel_t;

// Register-register layout
typedef struct packed {
    logic [6:0]                funct7;
    logic [`KRONOS_REG_AW-1:0] rs2;
    logic [`KRONOS_REG_AW-1:0] rs1;
    logic [2:0]                funct3;
    logic [`KRONOS_REG_AW-1:0] rd;
    logic [6:0]                opcode;
} r_fmt_t;

// Register-immediate layout
typedef struct packed {
    logic [11:0]               imm12;
    logic [`KRONOS_REG_AW-1:0] rs1;
    logic [2:0]                funct3;
    logic [`KRONOS_REG_AW-1:0] rd;
    logic [6:0]                opcode;
} i_fmt_t;

// One instruction word, two views
typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
} instr_t;

// Decode to execute
typedef struct packed {
    logic [`KRONOS_XLEN-1:0]   op1;
    logic [`KRONOS_XLEN-1:0]   op2;
    logic [`KRONOS_REG_AW-1:0] rs1;
    logic [`KRONOS_REG_AW-1:0] rs2;
    logic                      rs1_read;
    logic                      rs2_read;
    logic [`KRONOS_REG_AW-1:0] rd;
    logic                      rd_write;
    alu_sel_t                  sel;
    logic                      neg;
    logic                      rev;
    logic                      cin;
    logic                      uns;
    logic                      eq;
    logic                      inv;
    logic                      shr;
    logic                      illegal;
} pipeIDEX_t;

// Execute to writeback, also the retire record
typedef struct packed {
    logic [`KRONOS_XLEN-1:0]   result1;
    logic [`KRONOS_REG_AW-1:0] rd;
    logic                      rd_write;
    logic                      illegal;
} pipeEXWB_t;

endpackage

// File: source/kronos_wb.sv
/* Writeback holding register
   Retire port, register write and forwarding source */

`include "kronos_defs.svh"

module kronos_wb (
    input  logic                      clk,
    input  logic                      rstz,
    input  kronos_types::pipeEXWB_t   execute,
    input  logic                      ex_vld,
    output logic                      ex_rdy,
    output kronos_types::pipeEXWB_t   retire,
    output logic                      retire_vld,
    input  logic                      retire_rdy,
    output logic                      wr_en,
    output logic [`KRONOS_REG_AW-1:0] wr_addr,
    output logic [`KRONOS_XLEN-1:0]   wr_data,
    output logic [`KRONOS_XLEN-1:0]   fwd_data,
    output logic                      fwd_vld
);

logic wb_vld;

// Single entry, takes a new result as the old one retires
assign ex_rdy     = ~wb_vld | retire_rdy;
assign retire_vld = wb_vld;

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) wb_vld <= 1'b0;
    else if (ex_rdy) wb_vld <= ex_vld;
end

always_ff @(posedge clk) begin
    if (ex_vld && ex_rdy) retire <= execute;
end

// Register write on the retire transfer
assign wr_en   = wb_vld & retire_rdy & retire.rd_write & ~retire.illegal;
assign wr_addr = retire.rd;
assign wr_data = retire.result1;

// Held value is not in the register file yet
assign fwd_data = retire.result1;
assign fwd_vld  = wb_vld & retire.rd_write;

endmodule

// File: verif/kronos_tb.sv
/* Testbench for the execute core
   Instruction table, register mirror, random retire back-pressure and checks */

`include "kronos_defs.svh"

module kronos_tb;

// Major opcodes and function codes, straight from the RV32I encoding
localparam logic [6:0] OP_REG  = 7'b0110011;
localparam logic [6:0] OP_IMM  = 7'b0010011;
localparam logic [6:0] F7_BASE = 7'h00;
localparam logic [6:0] F7_ALT  = 7'h20;
localparam logic [2:0] F3_ADD  = 3'd0;
localparam logic [2:0] F3_SLL  = 3'd1;
localparam logic [2:0] F3_SLT  = 3'd2;
localparam logic [2:0] F3_SLTU = 3'd3;
localparam logic [2:0] F3_XOR  = 3'd4;
localparam logic [2:0] F3_SR   = 3'd5;
localparam logic [2:0] F3_OR   = 3'd6;
localparam logic [2:0] F3_AND  = 3'd7;

// One table row, instruction word and expected illegal flag
typedef struct packed {
    logic [31:0] word;
    logic        illegal;
} row_t;

logic clk;
logic rstz;
kronos_types::instr_t    instr;
logic                    instr_vld;
logic                    instr_rdy;
kronos_types::pipeEXWB_t retire;
logic                    retire_vld;
logic                    retire_rdy;

row_t prog [$];
logic [`KRONOS_XLEN-1:0] mirror [`KRONOS_NREGS];
logic [31:0] lfsr;
int iss;
int ret_idx;
int cycles;
int limit;

kronos_core_ex u_kronos_core_ex (
    .clk        (clk),
    .rstz       (rstz),
    .instr      (instr),
    .instr_vld  (instr_vld),
    .instr_rdy  (instr_rdy),
    .retire     (retire),
    .retire_vld (retire_vld),
    .retire_rdy (retire_rdy)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// ========================================
// Helpers

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
    input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
    input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OP_IMM};
endfunction

// Galois LFSR, right shifting, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
endfunction

task automatic add_row(input logic [31:0] word, input logic illegal);
    prog.push_back({word, illegal});
endtask

task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "testbench stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got,
    input logic [31:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h (retire %0d)",
            name, got, exp, ret_idx));
    end
endtask

// Architectural result of one word against the mirror
task automatic predict(input logic [31:0] w, output logic [31:0] res, output logic legal);
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  f7;
    logic        is_imm;
    f7     = w[31:25];
    is_imm = w[6:0] == OP_IMM;
    a      = mirror[w[19:15]];
    b      = is_imm ? {{20{w[31]}}, w[31:20]} : mirror[w[24:20]];
    res    = '0;
    legal  = 1'b1;
    if (w[6:0] != OP_REG && !is_imm) legal = 1'b0;
    else begin
        case (w[14:12])
            F3_ADD: begin
                if (!is_imm && f7 == F7_ALT) res = a - b;
                else if (is_imm || f7 == F7_BASE) res = a + b;
                else legal = 1'b0;
            end
            F3_SLL: begin
                res   = a << b[4:0];
                legal = f7 == F7_BASE;
            end
            F3_SR: begin
                if (f7 == F7_BASE) res = a >> b[4:0];
                else if (f7 == F7_ALT) res = $signed(a) >>> b[4:0];
                else legal = 1'b0;
            end
            default: begin
                // Compares and logic ops share the funct7 rule
                case (w[14:12])
                    F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                    F3_SLTU: res = {31'b0, a < b};
                    F3_XOR:  res = a ^ b;
                    F3_OR:   res = a | b;
                    default: res = a & b;
                endcase
                legal = is_imm || f7 == F7_BASE;
            end
        endcase
    end
endtask

// Compares one retire with the mirror, then updates it
task automatic check_retire(input int idx);
    logic [31:0] res;
    logic        legal;
    row_t        row;
    row = prog[idx];
    predict(row.word, res, legal);
    check_value("retire.illegal", retire.illegal, row.illegal);
    check_value("retire.rd_write", retire.rd_write, legal);
    check_value("retire.rd", retire.rd, row.word[11:7]);
    if (legal) begin
        check_value("retire.result1", retire.result1, res);
        // x0 stays zero
        if (row.word[11:7] != 5'd0) mirror[row.word[11:7]] = res;
    end
endtask

// ========================================
// Instruction table

task automatic load_program();
    // Constants built from x0
    add_row(i_type(F3_ADD, 1, 0, 12'd1), 1'b0);
    add_row(i_type(F3_SLL, 2, 1, 12'd31), 1'b0);
    add_row(i_type(F3_ADD, 3, 2, 12'hfff), 1'b0);
    add_row(i_type(F3_ADD, 6, 0, 12'hfff), 1'b0);
    add_row(i_type(F3_SR, 7, 6, 12'd16), 1'b0);
    add_row(i_type(F3_ADD, 5, 0, 12'd16), 1'b0);
    // Adder, overflow wrap and carry across bit 16
    add_row(r_type(F7_BASE, F3_ADD, 4, 3, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_ADD, 8, 7, 1), 1'b0);
    add_row(r_type(F7_ALT, F3_ADD, 9, 1, 3), 1'b0);
    add_row(r_type(F7_ALT, F3_ADD, 10, 2, 1), 1'b0);
    add_row(i_type(F3_ADD, 11, 7, 12'h001), 1'b0);
    // Logic unit
    add_row(r_type(F7_BASE, F3_AND, 12, 6, 7), 1'b0);
    add_row(r_type(F7_BASE, F3_OR, 13, 2, 7), 1'b0);
    add_row(r_type(F7_BASE, F3_XOR, 14, 3, 6), 1'b0);
    add_row(i_type(F3_AND, 15, 6, 12'h0f0), 1'b0);
    add_row(i_type(F3_OR, 16, 2, 12'h800), 1'b0);
    add_row(i_type(F3_XOR, 17, 7, 12'hfff), 1'b0);
    // Compares, mixed signs and equal operands
    add_row(r_type(F7_BASE, F3_SLT, 18, 2, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_SLT, 19, 1, 2), 1'b0);
    add_row(r_type(F7_BASE, F3_SLTU, 20, 2, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_SLTU, 21, 1, 2), 1'b0);
    add_row(r_type(F7_BASE, F3_SLT, 22, 3, 3), 1'b0);
    add_row(r_type(F7_BASE, F3_SLTU, 23, 7, 7), 1'b0);
    add_row(r_type(F7_BASE, F3_SLT, 27, 3, 2), 1'b0);
    add_row(i_type(F3_SLT, 24, 6, 12'h000), 1'b0);
    add_row(i_type(F3_SLTU, 25, 1, 12'hfff), 1'b0);
    add_row(i_type(F3_SLT, 26, 2, 12'h800), 1'b0);
    // Shifts by 0, 1, 16 and 31
    add_row(i_type(F3_SLL, 28, 3, 12'd0), 1'b0);
    add_row(r_type(F7_BASE, F3_SLL, 28, 7, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_SLL, 29, 6, 5), 1'b0);
    add_row(i_type(F3_SLL, 30, 1, 12'd31), 1'b0);
    add_row(r_type(F7_BASE, F3_SR, 31, 6, 1), 1'b0);
    add_row(i_type(F3_SR, 28, 2, 12'd31), 1'b0);
    add_row(r_type(F7_ALT, F3_SR, 29, 2, 1), 1'b0);
    add_row(i_type(F3_SR, 30, 2, 12'h410), 1'b0);
    add_row(i_type(F3_SR, 31, 2, 12'h41f), 1'b0);
    add_row(i_type(F3_SR, 28, 3, 12'h41f), 1'b0);
    // Only the low five bits of rs2 count
    add_row(r_type(F7_BASE, F3_SR, 29, 6, 8), 1'b0);
    add_row(r_type(F7_ALT, F3_SR, 30, 6, 0), 1'b0);
    // Dependent chain, each reads the previous rd
    add_row(i_type(F3_ADD, 1, 1, 12'd3), 1'b0);
    add_row(r_type(F7_BASE, F3_ADD, 1, 1, 1), 1'b0);
    add_row(r_type(F7_ALT, F3_ADD, 2, 1, 3), 1'b0);
    add_row(r_type(F7_BASE, F3_XOR, 2, 2, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_SLL, 4, 2, 1), 1'b0);
    add_row(r_type(F7_ALT, F3_SR, 4, 4, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_ADD, 5, 4, 4), 1'b0);
    add_row(r_type(F7_BASE, F3_SLTU, 6, 5, 4), 1'b0);
    add_row(r_type(F7_BASE, F3_OR, 6, 6, 5), 1'b0);
    add_row(i_type(F3_SLT, 7, 6, 12'd5), 1'b0);
    add_row(r_type(F7_BASE, F3_AND, 7, 7, 6), 1'b0);
    add_row(r_type(F7_ALT, F3_ADD, 8, 7, 7), 1'b0);
    // Unknown opcodes and funct codes
    add_row(32'h0000_2083, 1'b1);
    add_row(32'h1234_50b7, 1'b1);
    add_row(r_type(7'h01, F3_ADD, 9, 1, 2), 1'b1);
    add_row(i_type(F3_SR, 9, 6, 12'h210), 1'b1);
    add_row(i_type(F3_SLL, 9, 6, 12'h421), 1'b1);
    add_row(r_type(F7_BASE, F3_ADD, 10, 9, 0), 1'b0);
    // Writes to x0 are dropped and never forwarded
    add_row(i_type(F3_ADD, 0, 1, 12'd5), 1'b0);
    add_row(r_type(F7_BASE, F3_ADD, 11, 0, 1), 1'b0);
    add_row(r_type(F7_BASE, F3_ADD, 0, 3, 3), 1'b0);
    add_row(i_type(F3_ADD, 12, 0, 12'd0), 1'b0);
    add_row(r_type(F7_ALT, F3_ADD, 13, 0, 0), 1'b0);
endtask

// ========================================
// Main sequence

initial begin
    rstz       = 1'b0;
    instr      = '0;
    instr_vld  = 1'b0;
    retire_rdy = 1'b0;
    lfsr       = 32'h19f6_e32d;
    iss        = 0;
    ret_idx    = 0;
    cycles     = 0;
    for (int i = 0; i < `KRONOS_NREGS; i++) mirror[i] = '0;
    load_program();
    limit = 20 * prog.size() + 50;

    // Two cycles of reset, released on a falling edge
    repeat (2) @(negedge clk);
    rstz = 1'b1;
    #1;
    check_value("instr_rdy", instr_rdy, 1'b1);
    check_value("retire_vld", retire_vld, 1'b0);

    while (ret_idx < prog.size()) begin
        @(negedge clk);
        retire_rdy = lfsr[0];
        lfsr       = lfsr_next(lfsr);
        instr_vld  = iss < prog.size();
        if (iss < prog.size()) instr = prog[iss].word;
        // Ready settles well before the next rising edge
        #1;
        if (instr_vld && instr_rdy) iss++;
        if (retire_vld && retire_rdy) begin
            check_retire(ret_idx);
            ret_idx++;
        end
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d of %0d instructions retired",
                cycles, ret_idx, prog.size()));
        end
    end

    // Nothing may retire twice
    instr_vld  = 1'b0;
    retire_rdy = 1'b1;
    repeat (8) begin
        @(negedge clk);
        #1;
        if (retire_vld) abort_run("An extra retire came after the last instruction");
    end

    $display("RESULT: PASS");
    $finish;
end

endmodule
